/* logic/vdma_macros.svh */
// --------------------------------------------------------------------------
// video frame DMA control plane
// shared widths, Wishbone register map, core ID and reset values
// --------------------------------------------------------------------------
`ifndef VDMA_MACROS_SVH
`define VDMA_MACROS_SVH

`define VDMA_ADDR_W         32
`define VDMA_WB_ADR_W       8
`define VDMA_WB_DAT_W       32
`define VDMA_INDEX_W        8

// data word is 4 bytes wide
`define VDMA_ADDR_MASK      32'hffff_fffc
`define VDMA_CORE_ID        32'h527a_1040

// register word offsets, byte offset >> 2
`define VDMA_REG_ID         8'h00
`define VDMA_REG_AUTOFLIP   8'h04
`define VDMA_REG_ADDR0      8'h08
`define VDMA_REG_ADDR1      8'h09
`define VDMA_REG_ADDR2      8'h0a
`define VDMA_REG_BUF_NEW    8'h0c
`define VDMA_REG_BUF_WRITE  8'h0d
`define VDMA_REG_BUF_READ   8'h0e

// write channel, byte 0x110..0x140
`define VDMA_REG_WCONTROL   8'h44
`define VDMA_REG_WSTATUS    8'h45
`define VDMA_REG_WINDEX     8'h47
`define VDMA_REG_WADDR      8'h48
`define VDMA_REG_WMON_ADDR  8'h50

// read channel, byte 0x210..0x240
`define VDMA_REG_RCONTROL   8'h84
`define VDMA_REG_RSTATUS    8'h85
`define VDMA_REG_RINDEX     8'h87
`define VDMA_REG_RADDR      8'h88
`define VDMA_REG_RMON_ADDR  8'h90

`define VDMA_INIT_AUTOFLIP  2'b11
`define VDMA_INIT_ADDR0     32'h0000_0000
`define VDMA_INIT_ADDR1     32'h0010_0000
`define VDMA_INIT_ADDR2     32'h0020_0000
`define VDMA_INIT_BUF       2'b11

`endif

/* logic/vdma_pkg.sv */
// --------------------------------------------------------------------------
// video frame DMA control plane types
// buffer number and the control register word
// --------------------------------------------------------------------------
`include "vdma_macros.svh"

package vdma_pkg;

    // 0..2 select a frame buffer, 3 means none assigned yet
    typedef logic [1:0] buf_idx_t;

    // control register, seen as a bus word or as its fields
    typedef union packed {
        logic [`VDMA_WB_DAT_W-1:0] raw;
        struct packed {
            logic [`VDMA_WB_DAT_W-4:0] rsvd;
            logic                      oneshot;
            logic                      update;
            logic                      enable;
        } ctl;
    } ctl_word_u;

endpackage

/* logic/vdma_regs.sv */
// --------------------------------------------------------------------------
// video frame DMA register file
// Wishbone slave with zero wait states, per-channel frame interrupt,
// update flag auto-clear and one-shot auto-stop
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vdma_macros.svh"

module vdma_regs
    import vdma_pkg::*;
(
    input  logic                      m_axi4_aclk,
    input  logic                      s_wb_rst_i,
    input  logic [`VDMA_WB_ADR_W-1:0] s_wb_adr_i,
    input  logic [`VDMA_WB_DAT_W-1:0] s_wb_dat_i,
    input  logic                      s_wb_we_i,
    input  logic                      s_wb_stb_i,
    output logic [`VDMA_WB_DAT_W-1:0] s_wb_dat_o,
    output logic                      s_wb_ack_o,

    input  logic                      wbusy_i,
    input  logic                      rbusy_i,
    input  logic [`VDMA_INDEX_W-1:0]  windex_i,
    input  logic [`VDMA_INDEX_W-1:0]  rindex_i,
    input  logic                      wdone_i,
    input  logic                      rdone_i,
    input  logic [`VDMA_ADDR_W-1:0]   wmon_addr_i,
    input  logic [`VDMA_ADDR_W-1:0]   rmon_addr_i,
    input  buf_idx_t                  buf_new_i,
    input  buf_idx_t                  buf_write_i,
    input  buf_idx_t                  buf_read_i,

    output logic                      wenable_o,
    output logic                      wupdate_o,
    output logic                      renable_o,
    output logic                      rupdate_o,
    output logic [1:0]                autoflip_o,
    output logic [`VDMA_ADDR_W-1:0]   addr0_o,
    output logic [`VDMA_ADDR_W-1:0]   addr1_o,
    output logic [`VDMA_ADDR_W-1:0]   addr2_o,
    output logic [`VDMA_ADDR_W-1:0]   waddr_o,
    output logic [`VDMA_ADDR_W-1:0]   raddr_o,
    output logic                      wirq_o,
    output logic                      rirq_o
);

    logic [1:0]               autoflip;
    logic [`VDMA_ADDR_W-1:0]  addr0, addr1, addr2;
    logic [`VDMA_ADDR_W-1:0]  waddr, raddr;
    logic                     wenable, wupdate, woneshot;
    logic                     renable, rupdate, roneshot;
    logic                     wirq, rirq;
    logic                     wb_wr;
    ctl_word_u                wr_word;
    ctl_word_u                rd_word;

    assign wb_wr   = s_wb_stb_i & s_wb_we_i;
    assign wr_word = s_wb_dat_i;

    // --------------------------------------------------------------------------
    // register write, interrupt and auto-clear
    // --------------------------------------------------------------------------
    always_ff @(posedge m_axi4_aclk) begin
        if (s_wb_rst_i) begin
            autoflip <= `VDMA_INIT_AUTOFLIP;
            addr0    <= `VDMA_INIT_ADDR0;
            addr1    <= `VDMA_INIT_ADDR1;
            addr2    <= `VDMA_INIT_ADDR2;
            waddr    <= '0;
            raddr    <= '0;
            wenable  <= 1'b0;
            wupdate  <= 1'b0;
            woneshot <= 1'b0;
            renable  <= 1'b0;
            rupdate  <= 1'b0;
            roneshot <= 1'b0;
            wirq     <= 1'b0;
            rirq     <= 1'b0;
        end else begin
            if (wb_wr) begin
                case (s_wb_adr_i)
                    `VDMA_REG_AUTOFLIP: autoflip <= s_wb_dat_i[1:0];
                    `VDMA_REG_ADDR0:    addr0    <= s_wb_dat_i & `VDMA_ADDR_MASK;
                    `VDMA_REG_ADDR1:    addr1    <= s_wb_dat_i & `VDMA_ADDR_MASK;
                    `VDMA_REG_ADDR2:    addr2    <= s_wb_dat_i & `VDMA_ADDR_MASK;
                    `VDMA_REG_WADDR:    waddr    <= s_wb_dat_i & `VDMA_ADDR_MASK;
                    `VDMA_REG_RADDR:    raddr    <= s_wb_dat_i & `VDMA_ADDR_MASK;
                    `VDMA_REG_WCONTROL: begin
                        wenable  <= wr_word.ctl.enable;
                        wupdate  <= wr_word.ctl.update;
                        woneshot <= wr_word.ctl.oneshot;
                    end
                    `VDMA_REG_RCONTROL: begin
                        renable  <= wr_word.ctl.enable;
                        rupdate  <= wr_word.ctl.update;
                        roneshot <= wr_word.ctl.oneshot;
                    end
                    default: ;
                endcase
            end

            // frame finished, overrides a bus write in the same cycle
            wirq <= wdone_i;
            if (wdone_i) begin
                if (!autoflip[0]) begin
                    wupdate <= 1'b0;
                end
                if (woneshot) begin
                    wenable  <= 1'b0;
                    woneshot <= 1'b0;
                end
            end

            rirq <= rdone_i;
            if (rdone_i) begin
                if (!autoflip[1]) begin
                    rupdate <= 1'b0;
                end
                if (roneshot) begin
                    renable  <= 1'b0;
                    roneshot <= 1'b0;
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // read decode
    // --------------------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        case (s_wb_adr_i)
            `VDMA_REG_ID:        rd_word.raw = `VDMA_CORE_ID;
            `VDMA_REG_AUTOFLIP:  rd_word.raw[1:0] = autoflip;
            `VDMA_REG_ADDR0:     rd_word.raw[`VDMA_ADDR_W-1:0] = addr0;
            `VDMA_REG_ADDR1:     rd_word.raw[`VDMA_ADDR_W-1:0] = addr1;
            `VDMA_REG_ADDR2:     rd_word.raw[`VDMA_ADDR_W-1:0] = addr2;
            `VDMA_REG_BUF_NEW:   rd_word.raw[1:0] = buf_new_i;
            `VDMA_REG_BUF_WRITE: rd_word.raw[1:0] = buf_write_i;
            `VDMA_REG_BUF_READ:  rd_word.raw[1:0] = buf_read_i;
            `VDMA_REG_WCONTROL: begin
                rd_word.ctl.enable  = wenable;
                rd_word.ctl.update  = wupdate;
                rd_word.ctl.oneshot = woneshot;
            end
            `VDMA_REG_WSTATUS:   rd_word.raw[0] = wbusy_i;
            `VDMA_REG_WINDEX:    rd_word.raw[`VDMA_INDEX_W-1:0] = windex_i;
            `VDMA_REG_WADDR:     rd_word.raw[`VDMA_ADDR_W-1:0] = waddr;
            `VDMA_REG_WMON_ADDR: rd_word.raw[`VDMA_ADDR_W-1:0] = wmon_addr_i;
            `VDMA_REG_RCONTROL: begin
                rd_word.ctl.enable  = renable;
                rd_word.ctl.update  = rupdate;
                rd_word.ctl.oneshot = roneshot;
            end
            `VDMA_REG_RSTATUS:   rd_word.raw[0] = rbusy_i;
            `VDMA_REG_RINDEX:    rd_word.raw[`VDMA_INDEX_W-1:0] = rindex_i;
            `VDMA_REG_RADDR:     rd_word.raw[`VDMA_ADDR_W-1:0] = raddr;
            `VDMA_REG_RMON_ADDR: rd_word.raw[`VDMA_ADDR_W-1:0] = rmon_addr_i;
            default: ;
        endcase
    end

    assign s_wb_dat_o = rd_word.raw;
    assign s_wb_ack_o = s_wb_stb_i;

    assign wenable_o  = wenable;
    assign wupdate_o  = wupdate;
    assign renable_o  = renable;
    assign rupdate_o  = rupdate;
    assign autoflip_o = autoflip;
    assign addr0_o    = addr0;
    assign addr1_o    = addr1;
    assign addr2_o    = addr2;
    assign waddr_o    = waddr;
    assign raddr_o    = raddr;
    assign wirq_o     = wirq;
    assign rirq_o     = rirq;

endmodule

/* logic/vdma_buf_flip.sv */
// --------------------------------------------------------------------------
// triple-buffer rotation
// tracks newest, write and read buffers and picks each channel's
// next frame address
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vdma_macros.svh"

module vdma_buf_flip
    import vdma_pkg::*;
(
    input  logic                    m_axi4_aclk,
    input  logic                    s_wb_rst_i,
    input  logic                    wstart_i,
    input  logic                    rstart_i,
    input  logic [1:0]              autoflip_i,
    input  logic [`VDMA_ADDR_W-1:0] addr0_i,
    input  logic [`VDMA_ADDR_W-1:0] addr1_i,
    input  logic [`VDMA_ADDR_W-1:0] addr2_i,
    input  logic [`VDMA_ADDR_W-1:0] waddr_i,
    input  logic [`VDMA_ADDR_W-1:0] raddr_i,
    output buf_idx_t                buf_new_o,
    output buf_idx_t                buf_write_o,
    output buf_idx_t                buf_read_o,
    output logic [`VDMA_ADDR_W-1:0] wnext_addr_o,
    output logic [`VDMA_ADDR_W-1:0] rnext_addr_o
);

    buf_idx_t buf_new, buf_write, buf_read;
    buf_idx_t next_new, next_write, next_read;

    // base address of a buffer, channel register while none assigned
    function automatic logic [`VDMA_ADDR_W-1:0] base_addr(
        input buf_idx_t                idx,
        input logic [`VDMA_ADDR_W-1:0] own
    );
        case (idx)
            2'd0:    return addr0_i;
            2'd1:    return addr1_i;
            2'd2:    return addr2_i;
            default: return own;
        endcase
    endfunction

    always_comb begin
        next_new   = buf_new;
        next_write = buf_write;
        next_read  = buf_read;

        // finished write buffer becomes the newest
        if (wstart_i) begin
            next_new = buf_write;
        end
        if (rstart_i) begin
            next_read = next_new;
        end
        // lowest free buffer, loop runs downward so 0 wins
        if (wstart_i) begin
            for (int i = 2; i >= 0; i--) begin
                if (next_read != buf_idx_t'(i) && buf_write != buf_idx_t'(i)) begin
                    next_write = buf_idx_t'(i);
                end
            end
        end
    end

    always_ff @(posedge m_axi4_aclk) begin
        if (s_wb_rst_i) begin
            buf_new   <= `VDMA_INIT_BUF;
            buf_write <= `VDMA_INIT_BUF;
            buf_read  <= `VDMA_INIT_BUF;
        end else begin
            buf_new   <= next_new;
            buf_write <= next_write;
            buf_read  <= next_read;
        end
    end

    assign wnext_addr_o = autoflip_i[0] ? base_addr(next_write, waddr_i) : waddr_i;
    assign rnext_addr_o = autoflip_i[1] ? base_addr(next_read, raddr_i) : raddr_i;

    assign buf_new_o   = buf_new;
    assign buf_write_o = buf_write;
    assign buf_read_o  = buf_read;

endmodule

/* logic/vdma_frame_seq.sv */
// --------------------------------------------------------------------------
// frame sequencer, one per channel
// idle / busy / done with start pulse, frame index and address latch
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vdma_macros.svh"

module vdma_frame_seq (
    input  logic                     m_axi4_aclk,
    input  logic                     s_wb_rst_i,
    input  logic                     enable_i,
    input  logic                     update_i,
    input  logic                     frame_end_i,
    input  logic [`VDMA_ADDR_W-1:0]  next_addr_i,
    output logic                     start_o,
    output logic                     busy_o,
    output logic                     done_o,
    output logic [`VDMA_INDEX_W-1:0] index_o,
    output logic [`VDMA_ADDR_W-1:0]  addr_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    logic [1:0]               state;
    logic [`VDMA_INDEX_W-1:0] index;
    logic [`VDMA_ADDR_W-1:0]  frame_addr;
    logic                     started;
    logic                     start;

    assign start = (state == ST_IDLE) & enable_i;

    always_ff @(posedge m_axi4_aclk) begin
        if (s_wb_rst_i) begin
            state   <= ST_IDLE;
            index   <= '0;
            started <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_BUSY;
                        started <= 1'b1;
                    end
                end
                ST_BUSY: begin
                    if (frame_end_i) begin
                        state <= ST_DONE;
                        index <= index + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // first frame always takes the address, later ones only on update
    always_ff @(posedge m_axi4_aclk) begin
        if (start && (!started || update_i)) begin
            frame_addr <= next_addr_i;
        end
    end

    assign start_o = start;
    assign busy_o  = (state == ST_BUSY);
    assign done_o  = (state == ST_DONE);
    assign index_o = index;
    assign addr_o  = frame_addr;

endmodule

/* logic/vdma_ctl_top.sv */
// --------------------------------------------------------------------------
// video frame DMA control plane top level
// register file, buffer rotation and the write and read sequencers
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vdma_macros.svh"

module vdma_ctl_top
    import vdma_pkg::*;
(
    input  logic                      m_axi4_aclk,
    input  logic                      s_wb_rst_i,
    input  logic [`VDMA_WB_ADR_W-1:0] s_wb_adr_i,
    input  logic [`VDMA_WB_DAT_W-1:0] s_wb_dat_i,
    input  logic                      s_wb_we_i,
    input  logic                      s_wb_stb_i,
    input  logic                      wframe_end_i,
    input  logic                      rframe_end_i,
    output logic [`VDMA_WB_DAT_W-1:0] s_wb_dat_o,
    output logic                      s_wb_ack_o,
    output logic                      wirq_o,
    output logic                      rirq_o,
    output logic                      wstart_o,
    output logic                      rstart_o,
    output logic [`VDMA_ADDR_W-1:0]   waddr_o,
    output logic [`VDMA_ADDR_W-1:0]   raddr_o
);

    logic                     wenable, wupdate, renable, rupdate;
    logic                     wbusy, rbusy, wdone, rdone;
    logic [`VDMA_INDEX_W-1:0] windex, rindex;
    logic [1:0]               autoflip;
    logic [`VDMA_ADDR_W-1:0]  addr0, addr1, addr2;
    logic [`VDMA_ADDR_W-1:0]  reg_waddr, reg_raddr;
    logic [`VDMA_ADDR_W-1:0]  wnext_addr, rnext_addr;
    buf_idx_t                 buf_new, buf_write, buf_read;

    vdma_regs regs0 (
        .m_axi4_aclk (m_axi4_aclk),
        .s_wb_rst_i  (s_wb_rst_i),
        .s_wb_adr_i  (s_wb_adr_i),
        .s_wb_dat_i  (s_wb_dat_i),
        .s_wb_we_i   (s_wb_we_i),
        .s_wb_stb_i  (s_wb_stb_i),
        .s_wb_dat_o  (s_wb_dat_o),
        .s_wb_ack_o  (s_wb_ack_o),
        .wbusy_i     (wbusy),
        .rbusy_i     (rbusy),
        .windex_i    (windex),
        .rindex_i    (rindex),
        .wdone_i     (wdone),
        .rdone_i     (rdone),
        .wmon_addr_i (waddr_o),
        .rmon_addr_i (raddr_o),
        .buf_new_i   (buf_new),
        .buf_write_i (buf_write),
        .buf_read_i  (buf_read),
        .wenable_o   (wenable),
        .wupdate_o   (wupdate),
        .renable_o   (renable),
        .rupdate_o   (rupdate),
        .autoflip_o  (autoflip),
        .addr0_o     (addr0),
        .addr1_o     (addr1),
        .addr2_o     (addr2),
        .waddr_o     (reg_waddr),
        .raddr_o     (reg_raddr),
        .wirq_o      (wirq_o),
        .rirq_o      (rirq_o)
    );

    vdma_buf_flip flip0 (
        .m_axi4_aclk  (m_axi4_aclk),
        .s_wb_rst_i   (s_wb_rst_i),
        .wstart_i     (wstart_o),
        .rstart_i     (rstart_o),
        .autoflip_i   (autoflip),
        .addr0_i      (addr0),
        .addr1_i      (addr1),
        .addr2_i      (addr2),
        .waddr_i      (reg_waddr),
        .raddr_i      (reg_raddr),
        .buf_new_o    (buf_new),
        .buf_write_o  (buf_write),
        .buf_read_o   (buf_read),
        .wnext_addr_o (wnext_addr),
        .rnext_addr_o (rnext_addr)
    );

    // write channel
    vdma_frame_seq wseq0 (
        .m_axi4_aclk (m_axi4_aclk),
        .s_wb_rst_i  (s_wb_rst_i),
        .enable_i    (wenable),
        .update_i    (wupdate),
        .frame_end_i (wframe_end_i),
        .next_addr_i (wnext_addr),
        .start_o     (wstart_o),
        .busy_o      (wbusy),
        .done_o      (wdone),
        .index_o     (windex),
        .addr_o      (waddr_o)
    );

    // read channel
    vdma_frame_seq rseq0 (
        .m_axi4_aclk (m_axi4_aclk),
        .s_wb_rst_i  (s_wb_rst_i),
        .enable_i    (renable),
        .update_i    (rupdate),
        .frame_end_i (rframe_end_i),
        .next_addr_i (rnext_addr),
        .start_o     (rstart_o),
        .busy_o      (rbusy),
        .done_o      (rdone),
        .index_o     (rindex),
        .addr_o      (raddr_o)
    );

endmodule

/* test/vdma_ctl_checker.sv */
// --------------------------------------------------------------------------
// protocol checks on the control plane top level
// Wishbone ack, interrupt pulse width and restart spacing
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module vdma_ctl_checker (
    input logic m_axi4_aclk,
    input logic s_wb_rst_i,
    input logic s_wb_stb_i,
    input logic s_wb_ack_o,
    input logic wirq_o,
    input logic rirq_o,
    input logic wstart_o
);

    // zero wait state slave
    ack_is_stb: assert property (@(posedge m_axi4_aclk) disable iff (s_wb_rst_i)
        s_wb_ack_o == s_wb_stb_i)
        else $error("Wishbone ack does not follow strobe");

    wirq_one_cycle: assert property (@(posedge m_axi4_aclk) disable iff (s_wb_rst_i)
        $past(wirq_o) |-> !wirq_o)
        else $error("write interrupt high for two cycles");

    rirq_one_cycle: assert property (@(posedge m_axi4_aclk) disable iff (s_wb_rst_i)
        $past(rirq_o) |-> !rirq_o)
        else $error("read interrupt high for two cycles");

    // a frame takes at least one busy and one done cycle
    wstart_spacing: assert property (@(posedge m_axi4_aclk) disable iff (s_wb_rst_i)
        ($past(wirq_o) || $past(wirq_o, 2)) |-> !$rose(wstart_o))
        else $error("write start too soon after interrupt");

endmodule

bind vdma_ctl_top vdma_ctl_checker chk0 (
    .m_axi4_aclk (m_axi4_aclk),
    .s_wb_rst_i  (s_wb_rst_i),
    .s_wb_stb_i  (s_wb_stb_i),
    .s_wb_ack_o  (s_wb_ack_o),
    .wirq_o      (wirq_o),
    .rirq_o      (rirq_o),
    .wstart_o    (wstart_o)
);

/* test/vdma_ctl_tb.sv */
// --------------------------------------------------------------------------
// video frame DMA control plane testbench
// table of bus and frame-end steps with expected reads, interrupts
// and start pulses
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "vdma_macros.svh"

module vdma_ctl_tb
    import vdma_pkg::*;
();

    localparam logic [1:0] OP_IDLE = 2'd0;
    localparam logic [1:0] OP_WR   = 2'd1;
    localparam logic [1:0] OP_RD   = 2'd2;

    typedef struct packed {
        logic [1:0]                op;
        logic [`VDMA_WB_ADR_W-1:0] adr;
        logic [`VDMA_WB_DAT_W-1:0] dat;
        logic                      wend;
        logic                      rend;
        logic [3:0]                pulse;
    } step_t;

    logic                      m_axi4_aclk = 1'b0;
    logic                      s_wb_rst_i;
    logic [`VDMA_WB_ADR_W-1:0] s_wb_adr_i;
    logic [`VDMA_WB_DAT_W-1:0] s_wb_dat_i;
    logic                      s_wb_we_i;
    logic                      s_wb_stb_i;
    logic                      wframe_end_i;
    logic                      rframe_end_i;
    logic [`VDMA_WB_DAT_W-1:0] s_wb_dat_o;
    logic                      s_wb_ack_o;
    logic                      wirq_o;
    logic                      rirq_o;
    logic                      wstart_o;
    logic                      rstart_o;
    logic [`VDMA_ADDR_W-1:0]   waddr_o;
    logic [`VDMA_ADDR_W-1:0]   raddr_o;

    step_t steps[$];

    always #2 m_axi4_aclk = ~m_axi4_aclk;

    vdma_ctl_top dut0 (.*);

    function automatic logic [`VDMA_WB_DAT_W-1:0] ctl_val(
        input logic en,
        input logic upd,
        input logic os
    );
        ctl_word_u w;
        w             = '0;
        w.ctl.enable  = en;
        w.ctl.update  = upd;
        w.ctl.oneshot = os;
        return w.raw;
    endfunction

    task automatic push_step(
        input logic [1:0]                op,
        input logic [`VDMA_WB_ADR_W-1:0] adr,
        input logic [`VDMA_WB_DAT_W-1:0] dat,
        input logic                      wend,
        input logic                      rend,
        input logic [3:0]                pulse
    );
        step_t s;
        s.op    = op;
        s.adr   = adr;
        s.dat   = dat;
        s.wend  = wend;
        s.rend  = rend;
        s.pulse = pulse;
        steps.push_back(s);
    endtask

    // --------------------------------------------------------------------------
    // step table, pulse column is {wirq_o, rirq_o, wstart_o, rstart_o}
    // seen during the step
    // --------------------------------------------------------------------------
    task automatic build_table();
        // state after reset
        push_step(OP_RD, `VDMA_REG_ID, `VDMA_CORE_ID, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_BUF_NEW, 32'h3, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_BUF_WRITE, 32'h3, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_BUF_READ, 32'h3, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WCONTROL, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_RCONTROL, 32'h0, 1'b0, 1'b0, 4'b0000);
        // address registers drop the two low bits
        push_step(OP_WR, `VDMA_REG_ADDR1, 32'h0010_0003, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_ADDR1, 32'h0010_0000, 1'b0, 1'b0, 4'b0000);
        push_step(OP_WR, `VDMA_REG_WADDR, 32'h0010_0003, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WADDR, 32'h0010_0000, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, 8'h03, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_WR, `VDMA_REG_ADDR0, 32'h0004_0000, 1'b0, 1'b0, 4'b0000);
        // write channel free running, buffers 0, 1, 0
        push_step(OP_WR, `VDMA_REG_WCONTROL, ctl_val(1'b1, 1'b1, 1'b0), 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WSTATUS, 32'h0, 1'b0, 1'b0, 4'b0010);
        push_step(OP_RD, `VDMA_REG_WSTATUS, 32'h1, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_BUF_WRITE, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WMON_ADDR, 32'h0004_0000, 1'b0, 1'b0, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b1, 1'b0, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WCONTROL, ctl_val(1'b1, 1'b1, 1'b0), 1'b0, 1'b0, 4'b1010);
        push_step(OP_RD, `VDMA_REG_BUF_NEW, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_BUF_WRITE, 32'h1, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WMON_ADDR, 32'h0010_0000, 1'b0, 1'b0, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b1, 1'b0, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WINDEX, 32'h2, 1'b0, 1'b0, 4'b1010);
        push_step(OP_RD, `VDMA_REG_BUF_NEW, 32'h1, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_BUF_WRITE, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WMON_ADDR, 32'h0004_0000, 1'b0, 1'b0, 4'b0000);
        // read start takes the newest buffer
        push_step(OP_WR, `VDMA_REG_RCONTROL, ctl_val(1'b1, 1'b1, 1'b0), 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_BUF_NEW, 32'h1, 1'b0, 1'b0, 4'b0001);
        push_step(OP_RD, `VDMA_REG_BUF_READ, 32'h1, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_RMON_ADDR, 32'h0010_0000, 1'b0, 1'b0, 4'b0000);
        // next write skips the buffer being read
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b1, 1'b0, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_BUF_READ, 32'h1, 1'b0, 1'b0, 4'b1010);
        push_step(OP_RD, `VDMA_REG_BUF_WRITE, 32'h2, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WMON_ADDR, 32'h0020_0000, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_BUF_NEW, 32'h0, 1'b0, 1'b0, 4'b0000);
        // read autoflip off, update clears after one frame
        push_step(OP_WR, `VDMA_REG_AUTOFLIP, 32'h1, 1'b0, 1'b0, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b0, 1'b1, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_RCONTROL, ctl_val(1'b1, 1'b0, 1'b0), 1'b0, 1'b0, 4'b0101);
        push_step(OP_RD, `VDMA_REG_RMON_ADDR, 32'h0010_0000, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_RSTATUS, 32'h1, 1'b0, 1'b0, 4'b0000);
        // one-shot write frame
        push_step(OP_WR, `VDMA_REG_WCONTROL, ctl_val(1'b1, 1'b0, 1'b1), 1'b0, 1'b0, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b1, 1'b0, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WCONTROL, 32'h0, 1'b0, 1'b0, 4'b1000);
        push_step(OP_RD, `VDMA_REG_WINDEX, 32'h4, 1'b0, 1'b0, 4'b0000);
        push_step(OP_RD, `VDMA_REG_WSTATUS, 32'h0, 1'b0, 1'b0, 4'b0000);
        push_step(OP_IDLE, 8'h00, 32'h0, 1'b0, 1'b0, 4'b0000);
    endtask

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // drive one step just after the falling edge, check before the rising edge
    task automatic run_step(input step_t s);
        s_wb_stb_i   = (s.op != OP_IDLE);
        s_wb_we_i    = (s.op == OP_WR);
        s_wb_adr_i   = s.adr;
        s_wb_dat_i   = (s.op == OP_WR) ? s.dat : '0;
        wframe_end_i = s.wend;
        rframe_end_i = s.rend;
        #1;
        assert ({wirq_o, rirq_o, wstart_o, rstart_o} == s.pulse) else begin
            $display("[FAIL] {wirq_o, rirq_o, wstart_o, rstart_o}: got %h expected %h",
                     {wirq_o, rirq_o, wstart_o, rstart_o}, s.pulse);
            stop_on_error();
        end
        assert (s_wb_ack_o == s_wb_stb_i) else begin
            $display("[FAIL] s_wb_ack_o: got %h expected %h", s_wb_ack_o, s_wb_stb_i);
            stop_on_error();
        end
        if (s.op == OP_RD) begin
            assert (s_wb_dat_o == s.dat) else begin
                $display("[FAIL] s_wb_dat_o at %h: got %h expected %h",
                         s.adr, s_wb_dat_o, s.dat);
                stop_on_error();
            end
            if (s.adr == `VDMA_REG_WMON_ADDR) begin
                assert (waddr_o == s.dat) else begin
                    $display("[FAIL] waddr_o: got %h expected %h", waddr_o, s.dat);
                    stop_on_error();
                end
            end
            if (s.adr == `VDMA_REG_RMON_ADDR) begin
                assert (raddr_o == s.dat) else begin
                    $display("[FAIL] raddr_o: got %h expected %h", raddr_o, s.dat);
                    stop_on_error();
                end
            end
        end
    endtask

    initial begin
        s_wb_rst_i   = 1'b1;
        s_wb_adr_i   = '0;
        s_wb_dat_i   = '0;
        s_wb_we_i    = 1'b0;
        s_wb_stb_i   = 1'b0;
        wframe_end_i = 1'b0;
        rframe_end_i = 1'b0;
        build_table();
        repeat (4) @(posedge m_axi4_aclk);
        @(negedge m_axi4_aclk);
        s_wb_rst_i = 1'b0;
        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i]);
            @(negedge m_axi4_aclk);
        end
        $display("Test OK");
        $finish;
    end

    // watchdog
    initial begin
        #1;
        repeat (steps.size() * 20) @(posedge m_axi4_aclk);
        $display("timeout, the step table did not finish in time");
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* build.f */
+incdir+logic
logic/vdma_pkg.sv
logic/vdma_regs.sv
logic/vdma_buf_flip.sv
logic/vdma_frame_seq.sv
logic/vdma_ctl_top.sv
test/vdma_ctl_checker.sv
test/vdma_ctl_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vdma_ctl_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
